/* all.f */
src/decodePkg.sv
src/instrDecode.sv
src/aluCtrl.sv
src/memCtrl.sv
src/flowCtrl.sv
src/wbCtrl.sv
src/controlUnit.sv
sim/controlUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= controlUnitTb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_PATTERN ?= sim failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_PATTERN)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;

	localparam int resetCycles = 8;
	localparam int directedCount = 60;
	localparam int randomCount = 2000;
	localparam int cycleLimit = 2 * (resetCycles + directedCount + randomCount);
	localparam int keptMax = 42;

	//////////////////////////////
	// Instruction field codes

	localparam logic [5:0]
		opSpecial = 6'h00, opRegimm = 6'h01, opJ = 6'h02, opJal = 6'h03,
		opBeq = 6'h04, opBne = 6'h05, opBlez = 6'h06, opBgtz = 6'h07,
		opAddi = 6'h08, opAddiu = 6'h09, opSlti = 6'h0a, opSltiu = 6'h0b,
		opAndi = 6'h0c, opOri = 6'h0d, opXori = 6'h0e, opLui = 6'h0f,
		opLb = 6'h20, opLh = 6'h21, opLw = 6'h23, opLbu = 6'h24, opLhu = 6'h25,
		opSb = 6'h28, opSh = 6'h29, opSw = 6'h2b;

	localparam logic [5:0]
		fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03, fnSllv = 6'h04,
		fnSrlv = 6'h06, fnSrav = 6'h07, fnJr = 6'h08, fnJalr = 6'h09,
		fnAdd = 6'h20, fnAddu = 6'h21, fnSub = 6'h22, fnSubu = 6'h23,
		fnAnd = 6'h24, fnOr = 6'h25, fnXor = 6'h26, fnNor = 6'h27,
		fnSlt = 6'h2a, fnSltu = 6'h2b;

	localparam logic [4:0] rtBltz = 5'h00, rtBgez = 5'h01;

	// Mult/div funcs, then unused opcodes, then REGIMM with other rt
	localparam logic [31:0] illegalWords [18] = '{
		32'h0000_0018, 32'h0000_0019, 32'h0000_001a, 32'h0000_001b,
		32'h0000_0010, 32'h0000_0011, 32'h0000_0012, 32'h0000_0013,
		32'h4000_0000, 32'h8800_0000, 32'h9800_0000, 32'hb800_0000,
		32'hfc00_0000, 32'h7000_0000,
		32'h0402_0000, 32'h0410_0000, 32'h0411_0000, 32'h041f_0000
	};

	typedef struct packed {
		logic [1:0] branch;
		logic [2:0] cond;
		logic extOp;
		logic [4:0] aluOp;
		logic aluSrc;
		logic memWrite;
		logic [1:0] storeOp;
		logic [2:0] loadOp;
		logic regWrite;
		logic [1:0] regDst;
		logic [1:0] wbSrc;
	} ctrlT;

	logic clk = 1'b0;
	logic rstN;
	logic [31:0] instr;
	logic [1:0] branch;
	logic [2:0] cond;
	logic extOp;
	logic [4:0] aluOp;
	logic aluSrc;
	logic memWrite;
	logic [1:0] storeOp;
	logic [2:0] loadOp;
	logic regWrite;
	logic [1:0] regDst;
	logic [1:0] wbSrc;

	logic [15:0] lfsr = 16'd7118;
	logic [31:0] keptWord [keptMax];
	logic [31:0] keptMask [keptMax];
	int keptCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int cycles = 0;
	ctrlT expReg;
	logic [31:0] expInstr;
	logic haveExp = 1'b0;

	controlUnit u_controlUnit (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.branch(branch),
		.cond(cond),
		.extOp(extOp),
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.memWrite(memWrite),
		.storeOp(storeOp),
		.loadOp(loadOp),
		.regWrite(regWrite),
		.regDst(regDst),
		.wbSrc(wbSrc)
	);

	initial
	begin
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// Reference model

	function automatic ctrlT rTypeAlu(input logic [4:0] op);
		ctrlT c;
		c = '0;
		c.aluOp = op;
		c.regWrite = 1'b1;
		c.regDst = decodePkg::DST_RD;
		c.wbSrc = decodePkg::WB_ALU;
		return c;
	endfunction

	function automatic ctrlT immediateAlu(input logic [4:0] op, input logic zeroExt);
		ctrlT c;
		c = '0;
		c.aluOp = op;
		c.aluSrc = 1'b1;
		c.extOp = zeroExt;
		c.regWrite = 1'b1;
		c.regDst = decodePkg::DST_RT;
		return c;
	endfunction

	function automatic ctrlT loadAccess(input logic [2:0] mode);
		ctrlT c;
		c = immediateAlu(decodePkg::ALU_ADD, 1'b0);
		c.wbSrc = decodePkg::WB_MEM;
		c.loadOp = mode;
		return c;
	endfunction

	function automatic ctrlT storeAccess(input logic [1:0] mode);
		ctrlT c;
		c = '0;
		c.aluOp = decodePkg::ALU_ADD;
		c.aluSrc = 1'b1;
		c.memWrite = 1'b1;
		c.storeOp = mode;
		return c;
	endfunction

	function automatic ctrlT controlTransfer(input logic [1:0] kind, input logic [2:0] test);
		ctrlT c;
		c = '0;
		c.branch = kind;
		c.cond = test;
		return c;
	endfunction

	function automatic ctrlT expectedControls(input logic [31:0] w);
		ctrlT c;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rt;
		op = w[31:26];
		rt = w[20:16];
		fn = w[5:0];
		// Unmatched encodings stay all inactive
		c = '0;
		case (op)
			opSpecial:
			begin
				case (fn)
					fnSll: c = rTypeAlu(decodePkg::ALU_SLL);
					fnSrl: c = rTypeAlu(decodePkg::ALU_SRL);
					fnSra: c = rTypeAlu(decodePkg::ALU_SRA);
					fnSllv: c = rTypeAlu(decodePkg::ALU_SLLV);
					fnSrlv: c = rTypeAlu(decodePkg::ALU_SRLV);
					fnSrav: c = rTypeAlu(decodePkg::ALU_SRAV);
					fnAdd: c = rTypeAlu(decodePkg::ALU_ADD);
					fnAddu: c = rTypeAlu(decodePkg::ALU_ADDU);
					fnSub: c = rTypeAlu(decodePkg::ALU_SUB);
					fnSubu: c = rTypeAlu(decodePkg::ALU_SUBU);
					fnAnd: c = rTypeAlu(decodePkg::ALU_AND);
					fnOr: c = rTypeAlu(decodePkg::ALU_OR);
					fnXor: c = rTypeAlu(decodePkg::ALU_XOR);
					fnNor: c = rTypeAlu(decodePkg::ALU_NOR);
					fnSlt: c = rTypeAlu(decodePkg::ALU_SLT);
					fnSltu: c = rTypeAlu(decodePkg::ALU_SLTU);
					fnJr: c = controlTransfer(decodePkg::BR_JUMPREG, decodePkg::COND_NONE);
					fnJalr:
					begin
						c = controlTransfer(decodePkg::BR_JUMPREG, decodePkg::COND_NONE);
						c.regWrite = 1'b1;
						c.regDst = decodePkg::DST_RD;
						c.wbSrc = decodePkg::WB_LINK;
					end
					default: c = '0;
				endcase
			end
			opRegimm:
			begin
				if (rt == rtBltz)
					c = controlTransfer(decodePkg::BR_COND, decodePkg::COND_LTZ);
				else if (rt == rtBgez)
					c = controlTransfer(decodePkg::BR_COND, decodePkg::COND_GEZ);
			end
			opJ: c = controlTransfer(decodePkg::BR_JUMP, decodePkg::COND_NONE);
			opJal:
			begin
				c = controlTransfer(decodePkg::BR_JUMP, decodePkg::COND_NONE);
				c.regWrite = 1'b1;
				c.regDst = decodePkg::DST_RA;
				c.wbSrc = decodePkg::WB_LINK;
			end
			opBeq: c = controlTransfer(decodePkg::BR_COND, decodePkg::COND_EQ);
			opBne: c = controlTransfer(decodePkg::BR_COND, decodePkg::COND_NE);
			opBlez: c = controlTransfer(decodePkg::BR_COND, decodePkg::COND_LEZ);
			opBgtz: c = controlTransfer(decodePkg::BR_COND, decodePkg::COND_GTZ);
			opAddi: c = immediateAlu(decodePkg::ALU_ADD, 1'b0);
			opAddiu: c = immediateAlu(decodePkg::ALU_ADDU, 1'b0);
			opSlti: c = immediateAlu(decodePkg::ALU_SLT, 1'b0);
			opSltiu: c = immediateAlu(decodePkg::ALU_SLTU, 1'b0);
			opAndi: c = immediateAlu(decodePkg::ALU_AND, 1'b1);
			opOri: c = immediateAlu(decodePkg::ALU_OR, 1'b1);
			opXori: c = immediateAlu(decodePkg::ALU_XOR, 1'b1);
			opLui: c = immediateAlu(decodePkg::ALU_LUI, 1'b0);
			opLb: c = loadAccess(decodePkg::LOAD_BYTES);
			opLbu: c = loadAccess(decodePkg::LOAD_BYTEU);
			opLh: c = loadAccess(decodePkg::LOAD_HALFS);
			opLhu: c = loadAccess(decodePkg::LOAD_HALFU);
			opLw: c = loadAccess(decodePkg::LOAD_WORD);
			opSb: c = storeAccess(decodePkg::STORE_BYTE);
			opSh: c = storeAccess(decodePkg::STORE_HALF);
			opSw: c = storeAccess(decodePkg::STORE_WORD);
			default: c = '0;
		endcase
		return c;
	endfunction

	//////////////////////////////
	// Stimulus helpers

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	// Mask marks the bits that select the instruction
	task automatic addKept(input logic [5:0] op, input logic [4:0] rt, input logic [5:0] fn);
		keptWord[keptCount] = {op, 5'd0, rt, 10'd0, fn};
		if (op == opSpecial)
			keptMask[keptCount] = 32'hfc00_003f;
		else if (op == opRegimm)
			keptMask[keptCount] = 32'hfc1f_0000;
		else
			keptMask[keptCount] = 32'hfc00_0000;
		keptCount++;
	endtask

	task automatic buildKeptTable();
		addKept(opLb, 5'd0, 6'd0);
		addKept(opLbu, 5'd0, 6'd0);
		addKept(opLh, 5'd0, 6'd0);
		addKept(opLhu, 5'd0, 6'd0);
		addKept(opLw, 5'd0, 6'd0);
		addKept(opSb, 5'd0, 6'd0);
		addKept(opSh, 5'd0, 6'd0);
		addKept(opSw, 5'd0, 6'd0);
		addKept(opSpecial, 5'd0, fnAdd);
		addKept(opSpecial, 5'd0, fnAddu);
		addKept(opSpecial, 5'd0, fnSub);
		addKept(opSpecial, 5'd0, fnSubu);
		addKept(opSpecial, 5'd0, fnAnd);
		addKept(opSpecial, 5'd0, fnOr);
		addKept(opSpecial, 5'd0, fnXor);
		addKept(opSpecial, 5'd0, fnNor);
		addKept(opAddi, 5'd0, 6'd0);
		addKept(opAddiu, 5'd0, 6'd0);
		addKept(opAndi, 5'd0, 6'd0);
		addKept(opOri, 5'd0, 6'd0);
		addKept(opXori, 5'd0, 6'd0);
		addKept(opSpecial, 5'd0, fnSll);
		addKept(opSpecial, 5'd0, fnSrl);
		addKept(opSpecial, 5'd0, fnSra);
		addKept(opSpecial, 5'd0, fnSllv);
		addKept(opSpecial, 5'd0, fnSrlv);
		addKept(opSpecial, 5'd0, fnSrav);
		addKept(opSpecial, 5'd0, fnSlt);
		addKept(opSpecial, 5'd0, fnSltu);
		addKept(opSlti, 5'd0, 6'd0);
		addKept(opSltiu, 5'd0, 6'd0);
		addKept(opLui, 5'd0, 6'd0);
		addKept(opBeq, 5'd0, 6'd0);
		addKept(opBne, 5'd0, 6'd0);
		addKept(opBlez, 5'd0, 6'd0);
		addKept(opBgtz, 5'd0, 6'd0);
		addKept(opRegimm, rtBltz, 6'd0);
		addKept(opRegimm, rtBgez, 6'd0);
		addKept(opJ, 5'd0, 6'd0);
		addKept(opJal, 5'd0, 6'd0);
		addKept(opSpecial, 5'd0, fnJalr);
		addKept(opSpecial, 5'd0, fnJr);
	endtask

	task automatic issue(input logic [31:0] w);
		@(posedge clk);
		instr <= w;
	endtask

	task automatic checkField(input string name, input logic [7:0] expv, input logic [7:0] actv);
		if (actv !== expv)
		begin
			errorCount++;
			$display("[ERROR] %s expected 0x%0h actual 0x%0h for instr 0x%08h",
				name, expv, actv, expInstr);
		end
	endtask

	//////////////////////////////
	// Driver

	initial
	begin
		logic [31:0] sel;
		logic [31:0] rnd;
		logic [31:0] pick;
		int idx;
		rstN = 1'b0;
		instr = '0;
		buildKeptTable();
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < keptCount; i++)
			issue(keptWord[i]);
		foreach (illegalWords[i])
			issue(illegalWords[i]);
		// Table entry with random free fields, or a fully random word
		for (int n = 0; n < randomCount; n++)
		begin
			takeBits(1, sel);
			takeBits(32, rnd);
			if (sel[0])
			begin
				takeBits(6, pick);
				idx = pick % keptCount;
				rnd = (rnd & ~keptMask[idx]) | (keptWord[idx] & keptMask[idx]);
			end
			issue(rnd);
		end
		repeat (3) @(posedge clk);
		$display("%0d errors in %0d checks", errorCount, checkCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Compare on the falling edge one cycle after each instruction
	initial
	begin
		@(posedge clk);
		forever
		begin
			@(negedge clk);
			if (haveExp)
			begin
				checkCount++;
				checkField("branch", 8'(expReg.branch), 8'(branch));
				checkField("cond", 8'(expReg.cond), 8'(cond));
				checkField("extOp", 8'(expReg.extOp), 8'(extOp));
				checkField("aluOp", 8'(expReg.aluOp), 8'(aluOp));
				checkField("aluSrc", 8'(expReg.aluSrc), 8'(aluSrc));
				checkField("memWrite", 8'(expReg.memWrite), 8'(memWrite));
				checkField("storeOp", 8'(expReg.storeOp), 8'(storeOp));
				checkField("loadOp", 8'(expReg.loadOp), 8'(loadOp));
				checkField("regWrite", 8'(expReg.regWrite), 8'(regWrite));
				checkField("regDst", 8'(expReg.regDst), 8'(regDst));
				checkField("wbSrc", 8'(expReg.wbSrc), 8'(wbSrc));
			end
			// What the next rising edge will load
			expInstr = instr;
			expReg = rstN ? expectedControls(instr) : '0;
			haveExp = 1'b1;
		end
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= cycleLimit)
			begin
				$display("Timeout: run still going after %0d cycles", cycles);
				$display("sim failed");
				$finish;
			end
		end
	end

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input logic clk,
	input logic rstN,
	input decodePkg::instrWordT instr,
	output decodePkg::branchT branch,
	output decodePkg::condT cond,
	output logic extOp,
	output decodePkg::aluOpT aluOp,
	output logic aluSrc,
	output logic memWrite,
	output decodePkg::storeOpT storeOp,
	output decodePkg::loadOpT loadOp,
	output logic regWrite,
	output decodePkg::regDstT regDst,
	output decodePkg::wbSrcT wbSrc
);

	decodePkg::opcodeT op;
	decodePkg::funcT func;
	decodePkg::regAddrT rt;
	decodePkg::instrT instrId;

	decodePkg::branchT branchNext;
	decodePkg::condT condNext;
	logic extOpNext;
	decodePkg::aluOpT aluOpNext;
	logic aluSrcNext;
	logic memWriteNext;
	decodePkg::storeOpT storeOpNext;
	decodePkg::loadOpT loadOpNext;
	logic regWriteNext;
	decodePkg::regDstT regDstNext;
	decodePkg::wbSrcT wbSrcNext;

	assign op = instr[31:26];
	assign rt = instr[20:16];
	assign func = instr[5:0];

	instrDecode u_instrDecode (
		.op(op),
		.func(func),
		.rt(rt),
		.instrId(instrId)
	);

	aluCtrl u_aluCtrl (
		.instrId(instrId),
		.aluOp(aluOpNext),
		.aluSrc(aluSrcNext),
		.extOp(extOpNext)
	);

	memCtrl u_memCtrl (
		.instrId(instrId),
		.memWrite(memWriteNext),
		.storeOp(storeOpNext),
		.loadOp(loadOpNext)
	);

	flowCtrl u_flowCtrl (
		.instrId(instrId),
		.branch(branchNext),
		.cond(condNext)
	);

	wbCtrl u_wbCtrl (
		.instrId(instrId),
		.regWrite(regWriteNext),
		.regDst(regDstNext),
		.wbSrc(wbSrcNext)
	);

	//////////////////////////////
	// Decode-stage output register

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			branch <= decodePkg::BR_SEQ;
			cond <= decodePkg::COND_NONE;
			extOp <= 1'b0;
			aluOp <= decodePkg::ALU_ADDU;
			aluSrc <= 1'b0;
			memWrite <= 1'b0;
			storeOp <= decodePkg::STORE_WORD;
			loadOp <= decodePkg::LOAD_WORD;
			regWrite <= 1'b0;
			regDst <= decodePkg::DST_RD;
			wbSrc <= decodePkg::WB_ALU;
		end
		else
		begin
			branch <= branchNext;
			cond <= condNext;
			extOp <= extOpNext;
			aluOp <= aluOpNext;
			aluSrc <= aluSrcNext;
			memWrite <= memWriteNext;
			storeOp <= storeOpNext;
			loadOp <= loadOpNext;
			regWrite <= regWriteNext;
			regDst <= regDstNext;
			wbSrc <= wbSrcNext;
		end
	end

	// Registered controls from different generators stay consistent
	memRegExclusive: assert property (@(posedge clk) !(memWrite && regWrite));
	storeNeedsWrite: assert property (@(posedge clk)
		(storeOp != decodePkg::STORE_WORD) |-> memWrite);
	condOnlyOnBranch: assert property (@(posedge clk)
		(branch != decodePkg::BR_COND) |-> (cond == decodePkg::COND_NONE));

endmodule

/* src/wbCtrl.sv */
`timescale 1ns/1ps

module wbCtrl (
	input decodePkg::instrT instrId,
	output logic regWrite,
	output decodePkg::regDstT regDst,
	output decodePkg::wbSrcT wbSrc
);

	always_comb
	begin
		regWrite = 1'b1;
		regDst = decodePkg::DST_RD;
		wbSrc = decodePkg::WB_ALU;
		case (instrId)
			decodePkg::INSTR_ADD, decodePkg::INSTR_ADDU, decodePkg::INSTR_SUB,
			decodePkg::INSTR_SUBU, decodePkg::INSTR_AND, decodePkg::INSTR_OR,
			decodePkg::INSTR_XOR, decodePkg::INSTR_NOR, decodePkg::INSTR_SLL,
			decodePkg::INSTR_SRL, decodePkg::INSTR_SRA, decodePkg::INSTR_SLLV,
			decodePkg::INSTR_SRLV, decodePkg::INSTR_SRAV, decodePkg::INSTR_SLT,
			decodePkg::INSTR_SLTU: regDst = decodePkg::DST_RD;
			decodePkg::INSTR_ADDI, decodePkg::INSTR_ADDIU, decodePkg::INSTR_ANDI,
			decodePkg::INSTR_ORI, decodePkg::INSTR_XORI, decodePkg::INSTR_SLTI,
			decodePkg::INSTR_SLTIU, decodePkg::INSTR_LUI: regDst = decodePkg::DST_RT;
			decodePkg::INSTR_LB, decodePkg::INSTR_LBU, decodePkg::INSTR_LH,
			decodePkg::INSTR_LHU, decodePkg::INSTR_LW:
			begin
				regDst = decodePkg::DST_RT;
				wbSrc = decodePkg::WB_MEM;
			end
			// Return address goes to r31
			decodePkg::INSTR_JAL:
			begin
				regDst = decodePkg::DST_RA;
				wbSrc = decodePkg::WB_LINK;
			end
			decodePkg::INSTR_JALR: wbSrc = decodePkg::WB_LINK;
			default: regWrite = 1'b0;
		endcase
	end

endmodule

/* src/flowCtrl.sv */
`timescale 1ns/1ps

module flowCtrl (
	input decodePkg::instrT instrId,
	output decodePkg::branchT branch,
	output decodePkg::condT cond
);

	always_comb
	begin
		branch = decodePkg::BR_COND;
		cond = decodePkg::COND_NONE;
		case (instrId)
			decodePkg::INSTR_BEQ: cond = decodePkg::COND_EQ;
			decodePkg::INSTR_BNE: cond = decodePkg::COND_NE;
			decodePkg::INSTR_BLEZ: cond = decodePkg::COND_LEZ;
			decodePkg::INSTR_BGTZ: cond = decodePkg::COND_GTZ;
			decodePkg::INSTR_BLTZ: cond = decodePkg::COND_LTZ;
			decodePkg::INSTR_BGEZ: cond = decodePkg::COND_GEZ;
			// Target from the 26-bit index
			decodePkg::INSTR_J, decodePkg::INSTR_JAL: branch = decodePkg::BR_JUMP;
			// Target from rs
			decodePkg::INSTR_JR, decodePkg::INSTR_JALR: branch = decodePkg::BR_JUMPREG;
			default: branch = decodePkg::BR_SEQ;
		endcase
	end

endmodule

/* src/memCtrl.sv */
`timescale 1ns/1ps

module memCtrl (
	input decodePkg::instrT instrId,
	output logic memWrite,
	output decodePkg::storeOpT storeOp,
	output decodePkg::loadOpT loadOp
);

	// Store byte-enable mode
	always_comb
	begin
		case (instrId)
			decodePkg::INSTR_SB: storeOp = decodePkg::STORE_BYTE;
			decodePkg::INSTR_SH: storeOp = decodePkg::STORE_HALF;
			default: storeOp = decodePkg::STORE_WORD;
		endcase
	end

	assign memWrite = (instrId == decodePkg::INSTR_SB) || (instrId == decodePkg::INSTR_SH)
		|| (instrId == decodePkg::INSTR_SW);

	// Word extraction for LW and for everything that does not load
	always_comb
	begin
		case (instrId)
			decodePkg::INSTR_LB: loadOp = decodePkg::LOAD_BYTES;
			decodePkg::INSTR_LBU: loadOp = decodePkg::LOAD_BYTEU;
			decodePkg::INSTR_LH: loadOp = decodePkg::LOAD_HALFS;
			decodePkg::INSTR_LHU: loadOp = decodePkg::LOAD_HALFU;
			default: loadOp = decodePkg::LOAD_WORD;
		endcase
	end

endmodule

/* src/aluCtrl.sv */
`timescale 1ns/1ps

module aluCtrl (
	input decodePkg::instrT instrId,
	output decodePkg::aluOpT aluOp,
	output logic aluSrc,
	output logic extOp
);

	// Address arithmetic for loads and stores is a signed add
	always_comb
	begin
		case (instrId)
			decodePkg::INSTR_LB, decodePkg::INSTR_LBU, decodePkg::INSTR_LH,
			decodePkg::INSTR_LHU, decodePkg::INSTR_LW, decodePkg::INSTR_SB,
			decodePkg::INSTR_SH, decodePkg::INSTR_SW, decodePkg::INSTR_ADD,
			decodePkg::INSTR_ADDI: aluOp = decodePkg::ALU_ADD;
			decodePkg::INSTR_SUB: aluOp = decodePkg::ALU_SUB;
			decodePkg::INSTR_SUBU: aluOp = decodePkg::ALU_SUBU;
			decodePkg::INSTR_AND, decodePkg::INSTR_ANDI: aluOp = decodePkg::ALU_AND;
			decodePkg::INSTR_OR, decodePkg::INSTR_ORI: aluOp = decodePkg::ALU_OR;
			decodePkg::INSTR_XOR, decodePkg::INSTR_XORI: aluOp = decodePkg::ALU_XOR;
			decodePkg::INSTR_NOR: aluOp = decodePkg::ALU_NOR;
			decodePkg::INSTR_LUI: aluOp = decodePkg::ALU_LUI;
			decodePkg::INSTR_SLL: aluOp = decodePkg::ALU_SLL;
			decodePkg::INSTR_SLLV: aluOp = decodePkg::ALU_SLLV;
			decodePkg::INSTR_SRL: aluOp = decodePkg::ALU_SRL;
			decodePkg::INSTR_SRLV: aluOp = decodePkg::ALU_SRLV;
			decodePkg::INSTR_SRA: aluOp = decodePkg::ALU_SRA;
			decodePkg::INSTR_SRAV: aluOp = decodePkg::ALU_SRAV;
			decodePkg::INSTR_SLT, decodePkg::INSTR_SLTI: aluOp = decodePkg::ALU_SLT;
			decodePkg::INSTR_SLTU, decodePkg::INSTR_SLTIU: aluOp = decodePkg::ALU_SLTU;
			// ADDU, ADDIU, branches, jumps and illegal
			default: aluOp = decodePkg::ALU_ADDU;
		endcase
	end

	// Second operand from the immediate
	always_comb
	begin
		case (instrId)
			decodePkg::INSTR_LB, decodePkg::INSTR_LBU, decodePkg::INSTR_LH,
			decodePkg::INSTR_LHU, decodePkg::INSTR_LW, decodePkg::INSTR_SB,
			decodePkg::INSTR_SH, decodePkg::INSTR_SW, decodePkg::INSTR_ADDI,
			decodePkg::INSTR_ADDIU, decodePkg::INSTR_ANDI, decodePkg::INSTR_ORI,
			decodePkg::INSTR_XORI, decodePkg::INSTR_SLTI, decodePkg::INSTR_SLTIU,
			decodePkg::INSTR_LUI: aluSrc = 1'b1;
			default: aluSrc = 1'b0;
		endcase
	end

	// Zero extension only for the logical immediates
	assign extOp = (instrId == decodePkg::INSTR_ANDI) || (instrId == decodePkg::INSTR_ORI)
		|| (instrId == decodePkg::INSTR_XORI);

endmodule

/* src/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
	input decodePkg::opcodeT op,
	input decodePkg::funcT func,
	input decodePkg::regAddrT rt,
	output decodePkg::instrT instrId
);

	decodePkg::instrT specialId;
	decodePkg::instrT regimmId;

	// Mult/div codes of the SPECIAL group land in default
	always_comb
	begin
		case (func)
			decodePkg::FUNC_SLL: specialId = decodePkg::INSTR_SLL;
			decodePkg::FUNC_SRL: specialId = decodePkg::INSTR_SRL;
			decodePkg::FUNC_SRA: specialId = decodePkg::INSTR_SRA;
			decodePkg::FUNC_SLLV: specialId = decodePkg::INSTR_SLLV;
			decodePkg::FUNC_SRLV: specialId = decodePkg::INSTR_SRLV;
			decodePkg::FUNC_SRAV: specialId = decodePkg::INSTR_SRAV;
			decodePkg::FUNC_JR: specialId = decodePkg::INSTR_JR;
			decodePkg::FUNC_JALR: specialId = decodePkg::INSTR_JALR;
			decodePkg::FUNC_ADD: specialId = decodePkg::INSTR_ADD;
			decodePkg::FUNC_ADDU: specialId = decodePkg::INSTR_ADDU;
			decodePkg::FUNC_SUB: specialId = decodePkg::INSTR_SUB;
			decodePkg::FUNC_SUBU: specialId = decodePkg::INSTR_SUBU;
			decodePkg::FUNC_AND: specialId = decodePkg::INSTR_AND;
			decodePkg::FUNC_OR: specialId = decodePkg::INSTR_OR;
			decodePkg::FUNC_XOR: specialId = decodePkg::INSTR_XOR;
			decodePkg::FUNC_NOR: specialId = decodePkg::INSTR_NOR;
			decodePkg::FUNC_SLT: specialId = decodePkg::INSTR_SLT;
			decodePkg::FUNC_SLTU: specialId = decodePkg::INSTR_SLTU;
			default: specialId = decodePkg::INSTR_ILLEGAL;
		endcase
	end

	always_comb
	begin
		case (rt)
			decodePkg::RT_BLTZ: regimmId = decodePkg::INSTR_BLTZ;
			decodePkg::RT_BGEZ: regimmId = decodePkg::INSTR_BGEZ;
			default: regimmId = decodePkg::INSTR_ILLEGAL;
		endcase
	end

	always_comb
	begin
		case (op)
			decodePkg::OP_SPECIAL: instrId = specialId;
			decodePkg::OP_REGIMM: instrId = regimmId;
			decodePkg::OP_J: instrId = decodePkg::INSTR_J;
			decodePkg::OP_JAL: instrId = decodePkg::INSTR_JAL;
			decodePkg::OP_BEQ: instrId = decodePkg::INSTR_BEQ;
			decodePkg::OP_BNE: instrId = decodePkg::INSTR_BNE;
			decodePkg::OP_BLEZ: instrId = decodePkg::INSTR_BLEZ;
			decodePkg::OP_BGTZ: instrId = decodePkg::INSTR_BGTZ;
			decodePkg::OP_ADDI: instrId = decodePkg::INSTR_ADDI;
			decodePkg::OP_ADDIU: instrId = decodePkg::INSTR_ADDIU;
			decodePkg::OP_SLTI: instrId = decodePkg::INSTR_SLTI;
			decodePkg::OP_SLTIU: instrId = decodePkg::INSTR_SLTIU;
			decodePkg::OP_ANDI: instrId = decodePkg::INSTR_ANDI;
			decodePkg::OP_ORI: instrId = decodePkg::INSTR_ORI;
			decodePkg::OP_XORI: instrId = decodePkg::INSTR_XORI;
			decodePkg::OP_LUI: instrId = decodePkg::INSTR_LUI;
			decodePkg::OP_LB: instrId = decodePkg::INSTR_LB;
			decodePkg::OP_LH: instrId = decodePkg::INSTR_LH;
			decodePkg::OP_LW: instrId = decodePkg::INSTR_LW;
			decodePkg::OP_LBU: instrId = decodePkg::INSTR_LBU;
			decodePkg::OP_LHU: instrId = decodePkg::INSTR_LHU;
			decodePkg::OP_SB: instrId = decodePkg::INSTR_SB;
			decodePkg::OP_SH: instrId = decodePkg::INSTR_SH;
			decodePkg::OP_SW: instrId = decodePkg::INSTR_SW;
			default: instrId = decodePkg::INSTR_ILLEGAL;
		endcase
	end

endmodule

/* src/decodePkg.sv */
package decodePkg;

	typedef logic [31:0] instrWordT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] funcT;
	typedef logic [4:0] regAddrT;

	//////////////////////////////
	// Instruction field codes

	localparam opcodeT
		OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001, OP_J = 6'b000010,
		OP_JAL = 6'b000011, OP_BEQ = 6'b000100, OP_BNE = 6'b000101,
		OP_BLEZ = 6'b000110, OP_BGTZ = 6'b000111, OP_ADDI = 6'b001000,
		OP_ADDIU = 6'b001001, OP_SLTI = 6'b001010, OP_SLTIU = 6'b001011,
		OP_ANDI = 6'b001100, OP_ORI = 6'b001101, OP_XORI = 6'b001110,
		OP_LUI = 6'b001111, OP_LB = 6'b100000, OP_LH = 6'b100001,
		OP_LW = 6'b100011, OP_LBU = 6'b100100, OP_LHU = 6'b100101,
		OP_SB = 6'b101000, OP_SH = 6'b101001, OP_SW = 6'b101011;

	localparam funcT
		FUNC_SLL = 6'b000000, FUNC_SRL = 6'b000010, FUNC_SRA = 6'b000011,
		FUNC_SLLV = 6'b000100, FUNC_SRLV = 6'b000110, FUNC_SRAV = 6'b000111,
		FUNC_JR = 6'b001000, FUNC_JALR = 6'b001001, FUNC_ADD = 6'b100000,
		FUNC_ADDU = 6'b100001, FUNC_SUB = 6'b100010, FUNC_SUBU = 6'b100011,
		FUNC_AND = 6'b100100, FUNC_OR = 6'b100101, FUNC_XOR = 6'b100110,
		FUNC_NOR = 6'b100111, FUNC_SLT = 6'b101010, FUNC_SLTU = 6'b101011;

	// REGIMM picks its branch through the rt field
	localparam regAddrT RT_BLTZ = 5'b00000, RT_BGEZ = 5'b00001;

	//////////////////////////////
	// Decoded instruction and control encodings

	typedef enum logic [5:0] {
		INSTR_ILLEGAL,
		INSTR_LB, INSTR_LBU, INSTR_LH, INSTR_LHU, INSTR_LW,
		INSTR_SB, INSTR_SH, INSTR_SW,
		INSTR_ADD, INSTR_ADDU, INSTR_SUB, INSTR_SUBU,
		INSTR_AND, INSTR_OR, INSTR_XOR, INSTR_NOR,
		INSTR_ADDI, INSTR_ADDIU, INSTR_ANDI, INSTR_ORI, INSTR_XORI,
		INSTR_SLL, INSTR_SRL, INSTR_SRA, INSTR_SLLV, INSTR_SRLV, INSTR_SRAV,
		INSTR_SLT, INSTR_SLTU, INSTR_SLTI, INSTR_SLTIU,
		INSTR_LUI,
		INSTR_BEQ, INSTR_BNE, INSTR_BLEZ, INSTR_BGTZ, INSTR_BLTZ, INSTR_BGEZ,
		INSTR_J, INSTR_JAL, INSTR_JALR, INSTR_JR
	} instrT;

	typedef enum logic [4:0] {
		ALU_ADDU = 5'd0, ALU_ADD = 5'd1, ALU_SUBU = 5'd2, ALU_SUB = 5'd3,
		ALU_AND = 5'd4, ALU_OR = 5'd5, ALU_XOR = 5'd6, ALU_NOR = 5'd7,
		ALU_LUI = 5'd8,
		ALU_SLL = 5'd9, ALU_SLLV = 5'd10, ALU_SRL = 5'd11, ALU_SRLV = 5'd12,
		ALU_SRA = 5'd13, ALU_SRAV = 5'd14,
		ALU_SLTU = 5'd15, ALU_SLT = 5'd16
	} aluOpT;

	typedef enum logic [2:0] {
		LOAD_WORD = 3'd0, LOAD_BYTEU = 3'd1, LOAD_BYTES = 3'd2,
		LOAD_HALFU = 3'd3, LOAD_HALFS = 3'd4
	} loadOpT;

	typedef enum logic [1:0] {
		STORE_WORD = 2'd0, STORE_HALF = 2'd1, STORE_BYTE = 2'd2
	} storeOpT;

	typedef enum logic [1:0] {
		BR_SEQ = 2'd0, BR_COND = 2'd1, BR_JUMP = 2'd2, BR_JUMPREG = 2'd3
	} branchT;

	typedef enum logic [2:0] {
		COND_NONE = 3'd0, COND_EQ = 3'd1, COND_NE = 3'd2, COND_GEZ = 3'd3,
		COND_GTZ = 3'd4, COND_LEZ = 3'd5, COND_LTZ = 3'd6
	} condT;

	typedef enum logic [1:0] {
		DST_RD = 2'd0, DST_RT = 2'd1, DST_RA = 2'd2
	} regDstT;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0, WB_MEM = 2'd1, WB_LINK = 2'd2
	} wbSrcT;

endpackage
